/* dv/tb_rx_monitor.sv */
`default_nettype none
`timescale 1ns/10ps
`include "rx_monitor_settings.svh"

module tb_rx_monitor
	import rx_monitor_pkg::*;
();

	localparam int gap_cycles = 12;
	localparam int payload_bytes = 2 + `RX_DATA_BYTES;
	localparam int num_frames = 14;
	// longest frame has a bad byte pair, 7 preamble bytes, sfd, 7 copies per payload byte,
	// fcs and gap
	localparam int frame_max = 10 + payload_bytes * 7 + `RX_FCS_BYTES + gap_cycles;
	localparam int timeout_cycles = num_frames * frame_max * 2 + 1000;
	localparam int form_good = 0;
	localparam int form_no_sfd = 1;
	localparam int form_bad_preamble = 2;

	logic clk125MHz;
	logic reset;
	byte_t rx_data;
	logic rx_enable;
	logic [1:0] copy_sel;
	logic [1:0] count_sel;
	seg_num_t seg_num;
	byte_t data_byte;
	logic data_strobe;
	tally_t seg_count;
	tally_t ok_count;
	tally_t ng_count;
	tally_t lost_count;
	logic done;

	logic [31:0] rng;
	byte_t exp_data_q [$];
	seg_num_t exp_seg_q [$];
	tally_t exp_seg;
	tally_t exp_ok;
	tally_t exp_ng;
	tally_t exp_lost;
	seg_num_t exp_next;
	logic exp_done;
	logic done_at_reset;
	string test_name;
	int tests;
	int checks;
	int errors;
	int errors_at_start;

	rx_monitor_top i_dut (
		.clk125MHz(clk125MHz),
		.reset(reset),
		.rx_data(rx_data),
		.rx_enable(rx_enable),
		.copy_sel(copy_sel),
		.count_sel(count_sel),
		.seg_num(seg_num),
		.data_byte(data_byte),
		.data_strobe(data_strobe),
		.seg_count(seg_count),
		.ok_count(ok_count),
		.ng_count(ng_count),
		.lost_count(lost_count),
		.done(done)
	);

	initial begin
		clk125MHz = 1'b0;
		forever #4 clk125MHz = ~clk125MHz;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int copies_of(input logic [1:0] sel);
		return 2 * int'(sel) + 1;
	endfunction

	function automatic seg_num_t segments_of(input logic [1:0] sel);
		case (sel)
			2'b00: return 16'd1;
			2'b01: return 16'd50;
			2'b10: return 16'd100;
			default: return 16'd150;
		endcase
	endfunction

	// reference majority per bit over the first n copies
	function automatic byte_t majority(input byte_t group [7], input int n);
		byte_t result;
		int ones;
		result = '0;
		for (int b = 0; b < 8; b++) begin
			ones = 0;
			for (int c = 0; c < n; c++)
				ones += int'(group[c][b]);
			result[b] = (2 * ones > n);
		end
		return result;
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("FAIL %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		end
	endtask

	task automatic drive_byte(input byte_t b);
		@(posedge clk125MHz);
		#1;
		rx_data = b;
		rx_enable = 1'b1;
	endtask

	task automatic drive_gap(input int cycles);
		repeat (cycles) begin
			@(posedge clk125MHz);
			#1;
			rx_data = '0;
			rx_enable = 1'b0;
		end
	endtask

	task automatic check_counters();
		check({test_name, " pending bytes"}, 0, exp_data_q.size());
		check({test_name, " seg_count"}, exp_seg, seg_count);
		check({test_name, " ok_count"}, exp_ok, ok_count);
		check({test_name, " ng_count"}, exp_ng, ng_count);
		check({test_name, " lost_count"}, exp_lost, lost_count);
		check({test_name, " done"}, exp_done, done);
	endtask

	// bad_idx picks a data byte whose bits 0 and 7 flip in most copies
	task automatic send_frame(input seg_num_t seg, input bit minority, input int bad_idx,
			input int form);
		byte_t base [payload_bytes];
		byte_t group [7];
		byte_t voted;
		seg_num_t vseg;
		int n;
		int pre_len;
		bit seg_ok;
		n = copies_of(copy_sel);
		rng = xorshift(rng);
		pre_len = 1 + int'(rng % 7);
		seg_ok = 1'b1;
		vseg = '0;
		base[0] = seg[15:8];
		base[1] = seg[7:0];
		for (int k = 0; k < `RX_DATA_BYTES; k++)
			base[k + 2] = seg[7:0] + byte_t'(k);
		if (form == form_bad_preamble) begin
			drive_byte(`RX_PREAMBLE_BYTE);
			drive_byte(8'h12);
		end
		repeat (pre_len)
			drive_byte(`RX_PREAMBLE_BYTE);
		if (form != form_no_sfd)
			drive_byte(`RX_SFD_BYTE);
		for (int i = 0; i < payload_bytes; i++) begin
			group = '{default: '0};
			for (int c = 0; c < n; c++) begin
				rng = xorshift(rng);
				group[c] = base[i];
				if (minority && c < n / 2)
					group[c] = group[c] ^ rng[7:0];
				if (i >= 2 && i - 2 == bad_idx && c <= n / 2)
					group[c] = group[c] ^ 8'h81;
				drive_byte(group[c]);
			end
			voted = majority(group, n);
			if (i == 0) begin
				vseg[15:8] = voted;
			end else if (i == 1) begin
				vseg[7:0] = voted;
			end else if (form == form_good) begin
				exp_data_q.push_back(voted);
				exp_seg_q.push_back(vseg);
				if (voted != vseg[7:0] + byte_t'(i - 2))
					seg_ok = 1'b0;
			end
		end
		repeat (`RX_FCS_BYTES) begin
			rng = xorshift(rng);
			drive_byte(rng[15:8]);
		end
		drive_gap(gap_cycles);
		if (form == form_good) begin
			exp_seg++;
			if (seg_ok)
				exp_ok++;
			else
				exp_ng++;
			if (vseg > exp_next)
				exp_lost += tally_t'(vseg - exp_next);
			exp_next = vseg + 16'd1;
			if (vseg == segments_of(count_sel) - 16'd1)
				exp_done = 1'b1;
		end
		check_counters();
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic finish_test();
		tests++;
		if (errors == errors_at_start)
			$display("test %s: ok", test_name);
		else
			$display("test %s: %0d errors", test_name, errors - errors_at_start);
	endtask

	// each voted byte against the head of the expected queues
	always @(negedge clk125MHz) begin
		if (!reset && data_strobe) begin
			if (exp_data_q.size() == 0) begin
				errors++;
				$display("data_strobe seen in %s while no voted byte was expected", test_name);
			end else begin
				check({test_name, " data_byte"}, exp_data_q.pop_front(), data_byte);
				check({test_name, " seg_num"}, exp_seg_q.pop_front(), seg_num);
			end
		end
	end

	initial begin
		repeat (timeout_cycles) @(posedge clk125MHz);
		$display("watchdog timeout: the tests did not finish in time");
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		reset = 1'b1;
		rx_data = '0;
		rx_enable = 1'b0;
		copy_sel = 2'b00;
		count_sel = 2'b00;
		rng = 32'd3539;
		exp_seg = '0;
		exp_ok = '0;
		exp_ng = '0;
		exp_lost = '0;
		exp_next = '0;
		exp_done = 1'b0;
		tests = 0;
		checks = 0;
		errors = 0;
		test_name = "reset";
		repeat (8) @(posedge clk125MHz);
		#1;
		reset = 1'b0;
		done_at_reset = done;

		start_test("clean_frames");
		for (int s = 0; s < 3; s++)
			send_frame(seg_num_t'(s), 1'b0, -1, form_good);
		finish_test();

		start_test("minority_flips");
		copy_sel = 2'b01;
		send_frame(16'd3, 1'b1, -1, form_good);
		send_frame(16'd4, 1'b1, -1, form_good);
		copy_sel = 2'b10;
		send_frame(16'd5, 1'b1, -1, form_good);
		send_frame(16'd6, 1'b1, -1, form_good);
		finish_test();

		start_test("majority_flips");
		copy_sel = 2'b01;
		send_frame(16'd7, 1'b0, 5, form_good);
		copy_sel = 2'b11;
		send_frame(16'd8, 1'b0, 0, form_good);
		finish_test();

		start_test("skipped_segments");
		copy_sel = 2'b00;
		send_frame(16'd10, 1'b0, -1, form_good);
		send_frame(16'd15, 1'b0, -1, form_good);
		finish_test();

		start_test("malformed_frames");
		send_frame(16'd0, 1'b0, -1, form_no_sfd);
		send_frame(16'd0, 1'b0, -1, form_bad_preamble);
		finish_test();

		start_test("done_flag");
		send_frame(16'd16, 1'b0, -1, form_good);
		check("done_flag done after reset", 0, done_at_reset);
		check("done_flag done held", 1, done);
		finish_test();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* logic/error_tally.sv */
`default_nettype none
`timescale 1ns/10ps
`include "rx_monitor_settings.svh"

module error_tally
	import rx_monitor_pkg::*;
(
	input wire clk125MHz,
	input wire reset,
	input wire [1:0] count_sel,
	input wire seg_num_t seg_num,
	input wire byte_t data_byte,
	input wire data_strobe,
	input wire frame_done,
	output tally_t seg_count,
	output tally_t ok_count,
	output tally_t ng_count,
	output tally_t lost_count,
	output logic done
);

	localparam int cnt_w = $clog2(`RX_DATA_BYTES + 1);
	localparam logic [cnt_w-1:0] full_cnt = cnt_w'(`RX_DATA_BYTES);

	seg_num_t seg_max;
	seg_num_t next_seg;
	logic [cnt_w-1:0] byte_cnt;
	logic mismatch;
	byte_t expected;
	logic seg_good;

	// segments expected in one run
	always_comb begin
		unique case (count_sel)
			2'b00: seg_max = 16'd1;
			2'b01: seg_max = 16'd50;
			2'b10: seg_max = 16'd100;
			2'b11: seg_max = 16'd150;
		endcase
	end

	// pattern is low byte of segment plus byte index
	assign expected = seg_num[7:0] + byte_t'(byte_cnt);
	assign seg_good = !mismatch && (byte_cnt == full_cnt);

	always_ff @(posedge clk125MHz) begin
		if (reset) begin
			byte_cnt <= '0;
			mismatch <= 1'b0;
			next_seg <= '0;
			seg_count <= '0;
			ok_count <= '0;
			ng_count <= '0;
			lost_count <= '0;
			done <= 1'b0;
		end else if (frame_done) begin
			byte_cnt <= '0;
			mismatch <= 1'b0;
			// frames without any voted data carry no segment
			if (byte_cnt != '0) begin
				seg_count <= seg_count + 1'b1;
				if (seg_good)
					ok_count <= ok_count + 1'b1;
				else
					ng_count <= ng_count + 1'b1;
				if (seg_num > next_seg)
					lost_count <= lost_count + tally_t'(seg_num - next_seg);
				next_seg <= seg_num + 16'd1;
				if (seg_num == seg_max - 16'd1)
					done <= 1'b1;
			end
		end else if (data_strobe) begin
			if (byte_cnt == full_cnt) begin
				mismatch <= 1'b1;
			end else begin
				byte_cnt <= byte_cnt + 1'b1;
				if (data_byte != expected)
					mismatch <= 1'b1;
			end
		end
	end

	a_tally_sum: assert property (@(posedge clk125MHz) disable iff (reset)
		ok_count + ng_count == seg_count)
		else $error("ok and ng counts do not add up to seg_count");

endmodule

`default_nettype wire

/* logic/fcs_strip.sv */
`default_nettype none
`timescale 1ns/10ps
`include "rx_monitor_settings.svh"

module fcs_strip
	import rx_monitor_pkg::*;
(
	input wire clk125MHz,
	input wire reset,
	input wire byte_t rx_data,
	input wire rx_enable,
	input wire frame_active,
	output byte_t byte_data,
	output logic byte_strobe,
	output logic frame_end
);

	localparam int fill_w = $clog2(`RX_FCS_BYTES + 1);
	localparam logic [fill_w-1:0] fill_full = fill_w'(`RX_FCS_BYTES);

	byte_t shift_line [`RX_FCS_BYTES];
	logic [fill_w-1:0] fill;
	logic active_d;
	logic load;
	logic active_fall;

	// payload bytes only while the enable is still up
	assign load = frame_active && rx_enable;
	assign active_fall = active_d && !frame_active;

	always_ff @(posedge clk125MHz) begin
		if (reset) begin
			fill <= '0;
			active_d <= 1'b0;
			byte_strobe <= 1'b0;
			frame_end <= 1'b0;
		end else begin
			active_d <= frame_active;
			frame_end <= active_fall;
			byte_strobe <= load && (fill == fill_full);
			if (active_fall)
				fill <= '0;
			else if (load && (fill != fill_full))
				fill <= fill + 1'b1;
		end
	end

	// oldest byte leaves once the line holds a full fcs worth behind it
	always_ff @(posedge clk125MHz) begin
		if (load) begin
			byte_data <= shift_line[`RX_FCS_BYTES-1];
			shift_line[0] <= rx_data;
			for (int i = 1; i < `RX_FCS_BYTES; i++)
				shift_line[i] <= shift_line[i-1];
		end
	end

	a_strobe_in_frame: assert property (@(posedge clk125MHz) disable iff (reset)
		byte_strobe |-> $past(frame_active))
		else $error("byte_strobe outside an active frame");

endmodule

`default_nettype wire

/* logic/majority_vote.sv */
`default_nettype none
`timescale 1ns/10ps
`include "rx_monitor_settings.svh"

module majority_vote
	import rx_monitor_pkg::*;
(
	input wire clk125MHz,
	input wire reset,
	input wire [1:0] copy_sel,
	input wire byte_t byte_data,
	input wire byte_strobe,
	input wire frame_end,
	output seg_num_t seg_num,
	output byte_t data_byte,
	output logic data_strobe,
	output logic frame_done
);

	localparam int idx_w = $clog2(`RX_DATA_BYTES);
	localparam logic [idx_w-1:0] last_data_idx = idx_w'(`RX_DATA_BYTES - 1);

	copy_count_t copies;
	copy_count_t copy_idx;
	copy_count_t votes [8];
	copy_count_t votes_next [8];
	byte_t voted;
	byte_t seg_high_byte;
	logic last_copy;
	vote_field_t field;
	logic [idx_w-1:0] data_idx;

	// copies per byte
	always_comb begin
		unique case (copy_sel)
			2'b00: copies = 3'd1;
			2'b01: copies = 3'd3;
			2'b10: copies = 3'd5;
			2'b11: copies = 3'd7;
		endcase
	end

	// running count per bit including the current copy
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			votes_next[i] = votes[i] + copy_count_t'(byte_data[i]);
			voted[i] = {votes_next[i], 1'b0} > {1'b0, copies};
		end
	end

	assign last_copy = byte_strobe && (copy_idx == copies - 1'b1);

	always_ff @(posedge clk125MHz) begin
		if (reset) begin
			copy_idx <= '0;
			for (int i = 0; i < 8; i++)
				votes[i] <= '0;
			field <= vote_seg_high;
			data_idx <= '0;
			data_strobe <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			data_strobe <= 1'b0;
			frame_done <= frame_end;
			if (frame_end) begin
				// a partial copy group is dropped here
				copy_idx <= '0;
				for (int i = 0; i < 8; i++)
					votes[i] <= '0;
				field <= vote_seg_high;
				data_idx <= '0;
			end else if (last_copy) begin
				copy_idx <= '0;
				for (int i = 0; i < 8; i++)
					votes[i] <= '0;
				unique case (field)
					vote_seg_high: field <= vote_seg_low;
					vote_seg_low: field <= vote_data;
					vote_data: begin
						data_strobe <= 1'b1;
						data_idx <= data_idx + 1'b1;
						if (data_idx == last_data_idx)
							field <= vote_discard;
					end
					vote_discard: field <= vote_discard;
				endcase
			end else if (byte_strobe) begin
				copy_idx <= copy_idx + 1'b1;
				for (int i = 0; i < 8; i++)
					votes[i] <= votes_next[i];
			end
		end
	end

	// voted bytes into segment number or data
	always_ff @(posedge clk125MHz) begin
		if (last_copy && !frame_end) begin
			unique case (field)
				vote_seg_high: seg_high_byte <= voted;
				vote_seg_low: seg_num <= {seg_high_byte, voted};
				vote_data: data_byte <= voted;
				vote_discard: ;
			endcase
		end
	end

	a_copy_in_range: assert property (@(posedge clk125MHz) disable iff (reset)
		copy_idx < copies)
		else $error("copy counter beyond selected copy count");

endmodule

`default_nettype wire

/* logic/preamble_detect.sv */
`default_nettype none
`timescale 1ns/10ps
`include "rx_monitor_settings.svh"

module preamble_detect
	import rx_monitor_pkg::*;
(
	input wire clk125MHz,
	input wire reset,
	input wire byte_t rx_data,
	input wire rx_enable,
	output logic frame_active
);

	preamble_state_t state;
	preamble_state_t state_next;

	always_comb begin
		state_next = state;
		if (!rx_enable) begin
			// every frame ends when the enable drops
			state_next = pre_idle;
		end else begin
			unique case (state)
				pre_idle: begin
					if (rx_data == `RX_PREAMBLE_BYTE)
						state_next = pre_preamble;
					else
						state_next = pre_drain;
				end
				pre_preamble: begin
					if (rx_data == `RX_SFD_BYTE)
						state_next = pre_active;
					else if (rx_data != `RX_PREAMBLE_BYTE)
						state_next = pre_drain;
				end
				pre_active: state_next = pre_active;
				pre_drain: state_next = pre_drain;
			endcase
		end
	end

	always_ff @(posedge clk125MHz) begin
		if (reset)
			state <= pre_idle;
		else
			state <= state_next;
	end

	// high from the byte after the sfd
	assign frame_active = (state == pre_active);

	a_active_ends: assert property (@(posedge clk125MHz) disable iff (reset)
		!$past(rx_enable) |-> !frame_active)
		else $error("frame_active high after rx_enable dropped");

endmodule

`default_nettype wire

/* logic/rx_monitor_pkg.sv */
`default_nettype none

package rx_monitor_pkg;

	// received or voted byte
	typedef logic [7:0] byte_t;

	// segment number carried in the first two voted bytes
	typedef logic [15:0] seg_num_t;

	// statistics counter
	typedef logic [31:0] tally_t;

	// copies per byte, or votes per bit (up to 7)
	typedef logic [2:0] copy_count_t;

	typedef enum logic [1:0] {
		pre_idle,
		pre_preamble,
		pre_active,
		pre_drain
	} preamble_state_t;

	// which field the next voted byte belongs to
	typedef enum logic [1:0] {
		vote_seg_high,
		vote_seg_low,
		vote_data,
		vote_discard
	} vote_field_t;

endpackage

`default_nettype wire

/* logic/rx_monitor_settings.svh */
`ifndef RX_MONITOR_SETTINGS_SVH
`define RX_MONITOR_SETTINGS_SVH

// ethernet framing bytes
`define RX_PREAMBLE_BYTE 8'h55
`define RX_SFD_BYTE 8'hD5

// trailing frame check bytes, removed before voting
`define RX_FCS_BYTES 4

// voted data bytes that follow the two segment number bytes
`define RX_DATA_BYTES 16

`endif

/* logic/rx_monitor_top.sv */
`default_nettype none
`timescale 1ns/10ps

module rx_monitor_top
	import rx_monitor_pkg::*;
(
	input wire clk125MHz,
	input wire reset,
	input wire byte_t rx_data,
	input wire rx_enable,
	input wire [1:0] copy_sel,
	input wire [1:0] count_sel,
	output seg_num_t seg_num,
	output byte_t data_byte,
	output logic data_strobe,
	output tally_t seg_count,
	output tally_t ok_count,
	output tally_t ng_count,
	output tally_t lost_count,
	output logic done
);

	logic frame_active;
	byte_t byte_data;
	logic byte_strobe;
	logic frame_end;
	logic frame_done;

	preamble_detect i_preamble_detect (
		.clk125MHz(clk125MHz),
		.reset(reset),
		.rx_data(rx_data),
		.rx_enable(rx_enable),
		.frame_active(frame_active)
	);

	// strips fcs bytes off the raw input stream
	fcs_strip i_fcs_strip (
		.clk125MHz(clk125MHz),
		.reset(reset),
		.rx_data(rx_data),
		.rx_enable(rx_enable),
		.frame_active(frame_active),
		.byte_data(byte_data),
		.byte_strobe(byte_strobe),
		.frame_end(frame_end)
	);

	majority_vote i_majority_vote (
		.clk125MHz(clk125MHz),
		.reset(reset),
		.copy_sel(copy_sel),
		.byte_data(byte_data),
		.byte_strobe(byte_strobe),
		.frame_end(frame_end),
		.seg_num(seg_num),
		.data_byte(data_byte),
		.data_strobe(data_strobe),
		.frame_done(frame_done)
	);

	error_tally i_error_tally (
		.clk125MHz(clk125MHz),
		.reset(reset),
		.count_sel(count_sel),
		.seg_num(seg_num),
		.data_byte(data_byte),
		.data_strobe(data_strobe),
		.frame_done(frame_done),
		.seg_count(seg_count),
		.ok_count(ok_count),
		.ng_count(ng_count),
		.lost_count(lost_count),
		.done(done)
	);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_rx_monitor -f sim.f
./obj_dir/Vtb_rx_monitor | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* sim.f */
+incdir+logic
logic/rx_monitor_pkg.sv
logic/preamble_detect.sv
logic/fcs_strip.sv
logic/majority_vote.sv
logic/error_tally.sv
logic/rx_monitor_top.sv
dv/tb_rx_monitor.sv
